// ==== Makefile ====
# Verilator build and run for the FIX session layer testbench

TOP := tb_fix_session
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
fix_session_pkg.sv
session_event_dispatch.sv
session_engine.sv
order_arbiter.sv
fix_session_top.sv
tb_fix_session.sv

// ==== fix_session_pkg.sv ====
// FIX session layer shared types
// session states, event and message encodings, builder order codes
// and the event and order records passed between blocks

`default_nettype none

package fix_session_pkg;

	// state of one FIX session
	typedef enum logic [2:0] {
		ST_DISCONNECTED   = 3'd0,
		ST_LOGON_SENT     = 3'd1,
		ST_NORMAL         = 3'd2,
		ST_HEARTBEAT_SENT = 3'd3,
		ST_RESEND_SENT    = 3'd4,
		ST_LOGOUT_SENT    = 3'd5
	} session_state_e;

	// what happened on a host
	typedef enum logic [1:0] {
		EV_RX_MSG      = 2'd0, // inbound message classified
		EV_CONNECT     = 2'd1, // tcp link came up
		EV_TIMEOUT     = 2'd2, // heartbeat timer expired
		EV_END_SESSION = 2'd3  // application wants out
	} event_kind_e;

	// receive path verdict on an inbound message
	typedef enum logic [2:0] {
		VAL_VALID    = 3'd0,
		VAL_GARBLED  = 3'd1,
		VAL_SEQ_HIGH = 3'd2, // gap detected
		VAL_SEQ_LOW  = 3'd3, // fatal
		VAL_INVALID  = 3'd4
	} validity_e;

	// inbound FIX message type
	typedef enum logic [3:0] {
		MT_LOGON      = 4'd0,
		MT_LOGOUT     = 4'd1,
		MT_HEARTBEAT  = 4'd2,
		MT_TEST_REQ   = 4'd3,
		MT_RESEND_REQ = 4'd4,
		MT_GAP_FILL   = 4'd5,
		MT_SEQ_RESET  = 4'd6,
		MT_APP        = 4'd7
	} msg_type_e;

	// message builder commands, zero left free as "nothing"
	typedef enum logic [3:0] {
		ORD_LOGON      = 4'd1,
		ORD_LOGOUT     = 4'd2,
		ORD_HEARTBEAT  = 4'd3,
		ORD_RESEND_REQ = 4'd4
	} order_e;

	// one input event, 17 bits
	typedef struct packed {
		event_kind_e kind;
		logic [7:0]  host;     // only the low host index bits count
		msg_type_e   msg_type;
		validity_e   validity;
	} session_event_t;

	// order slot of one engine, 5 bits
	typedef struct packed {
		logic   pending;
		order_e code;
	} session_order_t;

endpackage

`default_nettype wire

// ==== fix_session_top.sv ====
// FIX session layer top
// event dispatcher, one session engine per host and the order arbiter
// driving the message builder over Wishbone

`timescale 1ns/1ns
`default_nettype none

module fix_session_top #(
	parameter int NUM_HOST = 4,
	parameter int HOST_W   = (NUM_HOST > 1) ? $clog2(NUM_HOST) : 1
) (
	input  wire                             clk,
	input  wire                             arst_n_i,
	input  wire                             event_valid_i,
	input  wire fix_session_pkg::session_event_t event_i,
	output wire                             event_ready_o,
	output wire                             wb_cyc_o,
	output wire                             wb_stb_o,
	output wire  [HOST_W-1:0]               wb_adr_o,
	output wire  [3:0]                      wb_dat_o,
	input  wire                             wb_ack_i,
	output wire  [NUM_HOST-1:0]             disconnect_o,
	output wire  [NUM_HOST-1:0]             seq_update_o,
	output wire  [NUM_HOST-1:0]             msg_accepted_o,
	output wire  [NUM_HOST-1:0]             msg_ignored_o
);

	wire fix_session_pkg::session_event_t                disp_event;
	wire [NUM_HOST-1:0]                                  eng_valid;
	wire [NUM_HOST-1:0]                                  eng_busy;
	wire [NUM_HOST-1:0]                                  order_done;
	wire fix_session_pkg::session_order_t [NUM_HOST-1:0] orders;

	session_event_dispatch #(
		.NUM_HOST(NUM_HOST),
		.HOST_W  (HOST_W)
	) u_dispatch (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.event_valid_i(event_valid_i),
		.event_i      (event_i),
		.event_ready_o(event_ready_o),
		.eng_valid_o  (eng_valid),
		.eng_event_o  (disp_event),
		.eng_busy_i   (eng_busy)
	);

	for (genvar h = 0; h < NUM_HOST; h++) begin : g_engine
		session_engine u_engine (
			.clk           (clk),
			.arst_n_i      (arst_n_i),
			.ev_valid_i    (eng_valid[h]),
			.ev_i          (disp_event),
			.busy_o        (eng_busy[h]),
			.order_o       (orders[h]),
			.order_done_i  (order_done[h]),
			.disconnect_o  (disconnect_o[h]),
			.seq_update_o  (seq_update_o[h]),
			.msg_accepted_o(msg_accepted_o[h]),
			.msg_ignored_o (msg_ignored_o[h])
		);
	end

	order_arbiter #(
		.NUM_HOST(NUM_HOST),
		.HOST_W  (HOST_W)
	) u_arbiter (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.orders_i    (orders),
		.order_done_o(order_done),
		.wb_cyc_o    (wb_cyc_o),
		.wb_stb_o    (wb_stb_o),
		.wb_adr_o    (wb_adr_o),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_i    (wb_ack_i)
	);

endmodule

`default_nettype wire

// ==== order_arbiter.sv ====
// round-robin arbiter over the engines' pending orders
// each grant becomes one Wishbone classic write: host on the address,
// order code on the data, held until ack

`timescale 1ns/1ns
`default_nettype none

module order_arbiter #(
	parameter int NUM_HOST = 4,
	parameter int HOST_W   = 2
) (
	input  wire                                             clk,
	input  wire                                             arst_n_i,
	input  wire fix_session_pkg::session_order_t [NUM_HOST-1:0] orders_i,
	output logic [NUM_HOST-1:0]                             order_done_o,
	output logic                                            wb_cyc_o,
	output logic                                            wb_stb_o,
	output logic [HOST_W-1:0]                               wb_adr_o,
	output logic [3:0]                                      wb_dat_o,
	input  wire                                             wb_ack_i
);

	typedef enum logic {
		ARB_IDLE,
		ARB_WRITE
	} arb_state_e;

	arb_state_e             state_q;
	logic [HOST_W-1:0]      last_q;    // last host served
	logic [HOST_W-1:0]      cur_q;     // host on the bus
	fix_session_pkg::order_e code_q;
	logic                   pick_valid;
	logic [HOST_W-1:0]      pick_idx;

	// first pending order, starting after last_q
	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick_idx   = '0;
		for (int i = 0; i < NUM_HOST; i++) begin
			idx = int'(last_q) + 1 + i;
			if (idx >= NUM_HOST) begin
				idx = idx - NUM_HOST;
			end
			if (!pick_valid && orders_i[idx].pending) begin
				pick_valid = 1'b1;
				pick_idx   = HOST_W'(idx);
			end
		end
	end

	always_comb begin
		order_done_o = '0;
		if (state_q == ARB_WRITE && wb_ack_i) begin
			order_done_o[cur_q] = 1'b1; // engine frees its slot on this edge
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ARB_IDLE;
			last_q  <= HOST_W'(NUM_HOST - 1); // host 0 goes first
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (pick_valid) begin
						state_q <= ARB_WRITE;
						last_q  <= pick_idx;
					end
				end
				default: begin
					if (wb_ack_i) begin
						state_q <= ARB_IDLE;
					end
				end
			endcase
		end
	end

	// bus payload, loaded only on grant
	always_ff @(posedge clk) begin
		if (state_q == ARB_IDLE && pick_valid) begin
			cur_q  <= pick_idx;
			code_q <= orders_i[pick_idx].code;
		end
	end

	assign wb_cyc_o = (state_q == ARB_WRITE);
	assign wb_stb_o = (state_q == ARB_WRITE);
	assign wb_adr_o = cur_q;
	assign wb_dat_o = code_q;

endmodule

`default_nettype wire

// ==== session_engine.sv ====
// FIX session state machine for one remote host
// decides builder orders, disconnects and sequence updates per event,
// keeps one pending order until the Wishbone side acknowledges it

`timescale 1ns/1ns
`default_nettype none

module session_engine (
	input  wire                             clk,
	input  wire                             arst_n_i,
	input  wire                             ev_valid_i,
	input  wire fix_session_pkg::session_event_t ev_i,
	output logic                            busy_o,
	output fix_session_pkg::session_order_t order_o,
	input  wire                             order_done_i,
	output logic                            disconnect_o,
	output logic                            seq_update_o,
	output logic                            msg_accepted_o,
	output logic                            msg_ignored_o
);

	fix_session_pkg::session_state_e state_q;
	fix_session_pkg::session_state_e state_d;
	fix_session_pkg::session_order_t order_q;
	fix_session_pkg::order_e         code_d;
	logic                            load_d;
	logic                            disc_d;
	logic                            sequp_d;
	logic                            acc_d;
	logic                            ign_d;

	always_comb begin
		state_d = state_q;
		code_d  = fix_session_pkg::ORD_LOGON;
		load_d  = 1'b0;
		disc_d  = 1'b0;
		sequp_d = 1'b0;
		acc_d   = 1'b0;
		ign_d   = 1'b0;
		case (ev_i.kind)
			fix_session_pkg::EV_CONNECT: begin
				load_d  = 1'b1; // fresh logon from any state
				state_d = fix_session_pkg::ST_LOGON_SENT;
			end
			fix_session_pkg::EV_END_SESSION: begin
				if (state_q == fix_session_pkg::ST_NORMAL ||
						state_q == fix_session_pkg::ST_HEARTBEAT_SENT ||
						state_q == fix_session_pkg::ST_RESEND_SENT) begin
					load_d  = 1'b1;
					code_d  = fix_session_pkg::ORD_LOGOUT;
					state_d = fix_session_pkg::ST_LOGOUT_SENT;
				end
			end
			fix_session_pkg::EV_TIMEOUT: begin
				if (state_q == fix_session_pkg::ST_NORMAL ||
						state_q == fix_session_pkg::ST_RESEND_SENT) begin
					load_d  = 1'b1;
					code_d  = fix_session_pkg::ORD_HEARTBEAT;
					state_d = fix_session_pkg::ST_HEARTBEAT_SENT;
				end else if (state_q != fix_session_pkg::ST_DISCONNECTED) begin
					disc_d  = 1'b1; // peer silent while we wait on it
					state_d = fix_session_pkg::ST_DISCONNECTED;
				end
			end
			default: begin
				// received message
				if (state_q == fix_session_pkg::ST_DISCONNECTED ||
						ev_i.validity == fix_session_pkg::VAL_GARBLED) begin
					ign_d = 1'b1;
				end else if (ev_i.validity == fix_session_pkg::VAL_SEQ_LOW ||
						ev_i.validity == fix_session_pkg::VAL_INVALID) begin
					disc_d  = 1'b1;
					state_d = fix_session_pkg::ST_DISCONNECTED;
				end else begin
					// only VALID or SEQ_HIGH left here
					case (state_q)
						fix_session_pkg::ST_LOGON_SENT: begin
							if (ev_i.msg_type != fix_session_pkg::MT_LOGON) begin
								disc_d  = 1'b1;
								state_d = fix_session_pkg::ST_DISCONNECTED;
							end else if (ev_i.validity == fix_session_pkg::VAL_VALID) begin
								acc_d   = 1'b1;
								state_d = fix_session_pkg::ST_NORMAL;
							end else begin
								load_d  = 1'b1; // logon ahead of our counter
								code_d  = fix_session_pkg::ORD_RESEND_REQ;
								state_d = fix_session_pkg::ST_RESEND_SENT;
							end
						end
						fix_session_pkg::ST_NORMAL,
						fix_session_pkg::ST_HEARTBEAT_SENT: begin
							if (ev_i.validity == fix_session_pkg::VAL_SEQ_HIGH) begin
								load_d  = 1'b1;
								code_d  = fix_session_pkg::ORD_RESEND_REQ;
								state_d = fix_session_pkg::ST_RESEND_SENT;
							end else if (ev_i.msg_type == fix_session_pkg::MT_LOGOUT) begin
								load_d  = 1'b1; // confirm peer logout
								code_d  = fix_session_pkg::ORD_LOGOUT;
								state_d = fix_session_pkg::ST_DISCONNECTED;
							end else if (ev_i.msg_type == fix_session_pkg::MT_TEST_REQ) begin
								load_d = 1'b1;
								code_d = fix_session_pkg::ORD_HEARTBEAT;
							end else begin
								acc_d   = 1'b1;
								state_d = fix_session_pkg::ST_NORMAL;
							end
						end
						fix_session_pkg::ST_RESEND_SENT: begin
							if (ev_i.msg_type == fix_session_pkg::MT_GAP_FILL ||
									ev_i.msg_type == fix_session_pkg::MT_SEQ_RESET) begin
								sequp_d = 1'b1; // gap closed
								state_d = fix_session_pkg::ST_NORMAL;
							end else if (ev_i.validity == fix_session_pkg::VAL_SEQ_HIGH) begin
								load_d = 1'b1;
								code_d = fix_session_pkg::ORD_RESEND_REQ;
							end else begin
								acc_d = 1'b1;
							end
						end
						default: begin
							// logout sent, waiting for the peer's logout
							if (ev_i.msg_type == fix_session_pkg::MT_LOGOUT) begin
								disc_d  = 1'b1;
								state_d = fix_session_pkg::ST_DISCONNECTED;
							end else if (ev_i.validity == fix_session_pkg::VAL_VALID) begin
								acc_d = 1'b1;
							end else begin
								ign_d = 1'b1;
							end
						end
					endcase
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q        <= fix_session_pkg::ST_DISCONNECTED;
			order_q        <= '0;
			disconnect_o   <= 1'b0;
			seq_update_o   <= 1'b0;
			msg_accepted_o <= 1'b0;
			msg_ignored_o  <= 1'b0;
		end else begin
			disconnect_o   <= ev_valid_i && disc_d; // one-cycle pulses
			seq_update_o   <= ev_valid_i && sequp_d;
			msg_accepted_o <= ev_valid_i && acc_d;
			msg_ignored_o  <= ev_valid_i && ign_d;
			if (ev_valid_i) begin
				state_q <= state_d;
			end
			if (ev_valid_i && load_d) begin
				order_q.pending <= 1'b1;
				order_q.code    <= code_d;
			end else if (order_done_i) begin
				order_q.pending <= 1'b0;
			end
		end
	end

	assign busy_o  = order_q.pending;
	assign order_o = order_q;

endmodule

`default_nettype wire

// ==== session_event_dispatch.sv ====
// FIX session event dispatcher
// one-entry holding register for input events, routed to the engine
// of the addressed host once that engine has no order pending

`timescale 1ns/1ns
`default_nettype none

module session_event_dispatch #(
	parameter int NUM_HOST = 4,
	parameter int HOST_W   = 2
) (
	input  wire                             clk,
	input  wire                             arst_n_i,
	input  wire                             event_valid_i,
	input  wire fix_session_pkg::session_event_t event_i,
	output logic                            event_ready_o,
	output logic [NUM_HOST-1:0]             eng_valid_o,
	output fix_session_pkg::session_event_t eng_event_o,
	input  wire  [NUM_HOST-1:0]             eng_busy_i
);

	logic                            full_q;
	fix_session_pkg::session_event_t ev_q;
	logic [HOST_W-1:0]               host_idx;
	logic [NUM_HOST-1:0]             host_sel;
	logic                            release_ev;

	assign host_idx = ev_q.host[HOST_W-1:0];

	// one-hot host decode
	always_comb begin
		host_sel = '0;
		for (int i = 0; i < NUM_HOST; i++) begin
			if (host_idx == HOST_W'(i)) begin
				host_sel[i] = 1'b1;
			end
		end
	end

	// a host beyond NUM_HOST selects nobody and simply drains
	assign release_ev    = full_q && ((host_sel & eng_busy_i) == '0);
	assign eng_valid_o   = release_ev ? host_sel : '0;
	assign eng_event_o   = ev_q;
	assign event_ready_o = !full_q || release_ev; // refill in the cycle it leaves

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			full_q <= 1'b0;
		end else if (event_valid_i && event_ready_o) begin
			full_q <= 1'b1;
		end else if (release_ev) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (event_valid_i && event_ready_o) begin
			ev_q <= event_i;
		end
	end

endmodule

`default_nettype wire

// ==== tb_fix_session.sv ====
// testbench for the FIX session layer
// drives host events, acts as the Wishbone slave (message builder) and
// checks orders and status pulses against a reference session model

`timescale 1ns/1ns
`default_nettype none

module tb_fix_session;

	localparam int NUM_HOST = 4;
	localparam int HOST_W   = 2;
	localparam int DEPTH    = 16;            // per-host expectation ring
	localparam logic [3:0] P_DISC = 4'b1000; // {disconnect, seq_update, accepted, ignored}
	localparam logic [3:0] P_SEQ  = 4'b0100;
	localparam logic [3:0] P_ACC  = 4'b0010;
	localparam logic [3:0] P_IGN  = 4'b0001;

	logic                            clk = 1'b0;
	logic                            arst_n;
	logic                            event_valid;
	fix_session_pkg::session_event_t ev_drv;
	wire                             event_ready;
	wire                             wb_cyc;
	wire                             wb_stb;
	wire  [HOST_W-1:0]               wb_adr;
	wire  [3:0]                      wb_dat;
	logic                            wb_ack = 1'b0;
	wire  [NUM_HOST-1:0]             disconnect;
	wire  [NUM_HOST-1:0]             seq_update;
	wire  [NUM_HOST-1:0]             accepted;
	wire  [NUM_HOST-1:0]             ignored;

	// reference model and expectation queues
	fix_session_pkg::session_state_e model_st [NUM_HOST];
	logic [3:0] pulse_q [NUM_HOST][DEPTH];
	int         pulse_head [NUM_HOST];
	int         pulse_tail [NUM_HOST];
	logic [3:0] ord_q [NUM_HOST][DEPTH];
	int         ord_head [NUM_HOST];
	int         ord_tail [NUM_HOST];
	logic [5:0] rx_q [$];                    // {host, order code} per write
	int         ack_cycle [NUM_HOST];
	int         pulse_cycle [NUM_HOST];
	logic [4*NUM_HOST-1:0] act_pv;
	logic [4*NUM_HOST-1:0] exp_pv;
	logic [3:0] exp_dat;

	int    cycle = 0;
	int    errors = 0;
	int    events_sent = 0;
	int    hold_cycles = 0;
	int    rx_start = 0;
	int    ack_wait = -1;
	logic  slow_ack = 1'b0;
	logic  timed_out = 1'b0;
	logic  stb_s;
	logic  ack_s;
	logic  [HOST_W-1:0] adr_s;
	logic  [3:0] dat_s;
	int    cyc_s;
	string test_name = "reset";

	fix_session_top #(.NUM_HOST(NUM_HOST)) dut_i (
		.clk           (clk),
		.arst_n_i      (arst_n),
		.event_valid_i (event_valid),
		.event_i       (ev_drv),
		.event_ready_o (event_ready),
		.wb_cyc_o      (wb_cyc),
		.wb_stb_o      (wb_stb),
		.wb_adr_o      (wb_adr),
		.wb_dat_o      (wb_dat),
		.wb_ack_i      (wb_ack),
		.disconnect_o  (disconnect),
		.seq_update_o  (seq_update),
		.msg_accepted_o(accepted),
		.msg_ignored_o (ignored)
	);

	always #5 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// next expected pulse for each host that pulses, next order on the bus address
	always_comb begin
		act_pv = '0;
		exp_pv = '0;
		for (int h = 0; h < NUM_HOST; h++) begin
			act_pv[h*4 +: 4] = {disconnect[h], seq_update[h], accepted[h], ignored[h]};
			if (act_pv[h*4 +: 4] != 4'd0 && pulse_head[h] != pulse_tail[h]) begin
				exp_pv[h*4 +: 4] = pulse_q[h][pulse_head[h] % DEPTH];
			end
		end
		exp_dat = 4'd0; // no order expected, never a legal code
		if (ord_head[wb_adr] != ord_tail[wb_adr]) begin
			exp_dat = ord_q[wb_adr][ord_head[wb_adr] % DEPTH];
		end
	end

	always @(posedge clk) begin
		if (arst_n) begin
			for (int h = 0; h < NUM_HOST; h++) begin
				if (act_pv[h*4 +: 4] != 4'd0) begin
					pulse_cycle[h] <= cycle;
					if (pulse_head[h] != pulse_tail[h]) begin
						pulse_head[h] <= pulse_head[h] + 1;
					end
				end
			end
		end
	end

	// message builder model, random ack latency
	always @(posedge clk) begin
		stb_s = wb_stb;
		ack_s = wb_ack;
		adr_s = wb_adr;
		dat_s = wb_dat;
		cyc_s = cycle;
		#1;
		if (!arst_n) begin
			wb_ack   = 1'b0;
			ack_wait = -1;
		end else if (stb_s && ack_s) begin
			rx_q.push_back({adr_s, dat_s});
			if (ord_head[adr_s] != ord_tail[adr_s]) begin
				ord_head[adr_s]++;
			end
			ack_cycle[adr_s] = cyc_s;
			wb_ack   = 1'b0;
			ack_wait = -1;
		end else if (stb_s) begin
			if (ack_wait < 0) begin
				ack_wait = int'($urandom_range(5, 0)) + (slow_ack ? 6 : 0);
			end
			if (ack_wait == 0) begin
				wb_ack = 1'b1;
			end else begin
				ack_wait--;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) act_pv == exp_pv)
		else report_value("status pulses", 32'($sampled(exp_pv)), 32'($sampled(act_pv)));
	assert property (@(posedge clk) disable iff (!arst_n) (wb_stb && wb_ack) |-> wb_dat == exp_dat)
		else report_value("write data", 32'($sampled(exp_dat)), 32'($sampled(wb_dat)));
	assert property (@(posedge clk) disable iff (!arst_n) wb_cyc == wb_stb)
		else report_value("cyc equals stb", 32'($sampled(wb_stb)), 32'($sampled(wb_cyc)));
	assert property (@(posedge clk) disable iff (!arst_n)
			(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat)))
		else report_text("write dropped or changed before its ack");
	assert property (@(posedge clk) disable iff (!arst_n) (wb_stb && wb_ack) |=> !wb_cyc)
		else report_text("cycle still open after the ack");

	task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
	endtask

	task automatic report_text(input string what);
		errors++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic finish_run();
		$display("events %0d, writes %0d, errors %0d", events_sent, rx_q.size(), errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	endtask

	// later waits are skipped once one has run out
	task automatic report_timeout(input string what);
		report_text({"timed out waiting for ", what});
		timed_out = 1'b1;
	endtask

	task automatic push_pulse(input int h, input logic [3:0] code);
		pulse_q[h][pulse_tail[h] % DEPTH] = code;
		pulse_tail[h]++;
	endtask

	task automatic push_order(input int h, input fix_session_pkg::order_e code);
		ord_q[h][ord_tail[h] % DEPTH] = code;
		ord_tail[h]++;
	endtask

	// session rules per accepted event
	task automatic apply_model(input fix_session_pkg::session_event_t ev);
		int h;
		fix_session_pkg::session_state_e st;
		h  = int'(ev.host[HOST_W-1:0]);
		st = model_st[h];
		if (ev.kind == fix_session_pkg::EV_CONNECT) begin
			push_order(h, fix_session_pkg::ORD_LOGON);
			st = fix_session_pkg::ST_LOGON_SENT;
		end else if (ev.kind == fix_session_pkg::EV_END_SESSION) begin
			if (st inside {fix_session_pkg::ST_NORMAL, fix_session_pkg::ST_HEARTBEAT_SENT,
					fix_session_pkg::ST_RESEND_SENT}) begin
				push_order(h, fix_session_pkg::ORD_LOGOUT);
				st = fix_session_pkg::ST_LOGOUT_SENT;
			end
		end else if (ev.kind == fix_session_pkg::EV_TIMEOUT) begin
			if (st inside {fix_session_pkg::ST_NORMAL, fix_session_pkg::ST_RESEND_SENT}) begin
				push_order(h, fix_session_pkg::ORD_HEARTBEAT);
				st = fix_session_pkg::ST_HEARTBEAT_SENT;
			end else if (st != fix_session_pkg::ST_DISCONNECTED) begin
				push_pulse(h, P_DISC);
				st = fix_session_pkg::ST_DISCONNECTED;
			end
		end else if (st == fix_session_pkg::ST_DISCONNECTED ||
				ev.validity == fix_session_pkg::VAL_GARBLED) begin
			push_pulse(h, P_IGN);
		end else if (ev.validity inside {fix_session_pkg::VAL_SEQ_LOW,
				fix_session_pkg::VAL_INVALID}) begin
			push_pulse(h, P_DISC);
			st = fix_session_pkg::ST_DISCONNECTED;
		end else if (st == fix_session_pkg::ST_LOGON_SENT) begin
			if (ev.msg_type != fix_session_pkg::MT_LOGON) begin
				push_pulse(h, P_DISC);
				st = fix_session_pkg::ST_DISCONNECTED;
			end else if (ev.validity == fix_session_pkg::VAL_VALID) begin
				push_pulse(h, P_ACC);
				st = fix_session_pkg::ST_NORMAL;
			end else begin
				push_order(h, fix_session_pkg::ORD_RESEND_REQ);
				st = fix_session_pkg::ST_RESEND_SENT;
			end
		end else if (st == fix_session_pkg::ST_RESEND_SENT) begin
			if (ev.msg_type inside {fix_session_pkg::MT_GAP_FILL, fix_session_pkg::MT_SEQ_RESET}) begin
				push_pulse(h, P_SEQ);
				st = fix_session_pkg::ST_NORMAL;
			end else if (ev.validity == fix_session_pkg::VAL_SEQ_HIGH) begin
				push_order(h, fix_session_pkg::ORD_RESEND_REQ);
			end else begin
				push_pulse(h, P_ACC);
			end
		end else if (st == fix_session_pkg::ST_LOGOUT_SENT) begin
			if (ev.msg_type == fix_session_pkg::MT_LOGOUT) begin
				push_pulse(h, P_DISC);
				st = fix_session_pkg::ST_DISCONNECTED;
			end else begin
				push_pulse(h, P_ACC);
			end
		end else if (ev.validity == fix_session_pkg::VAL_SEQ_HIGH) begin
			push_order(h, fix_session_pkg::ORD_RESEND_REQ); // normal or heartbeat sent
			st = fix_session_pkg::ST_RESEND_SENT;
		end else if (ev.msg_type == fix_session_pkg::MT_LOGOUT) begin
			push_order(h, fix_session_pkg::ORD_LOGOUT);
			st = fix_session_pkg::ST_DISCONNECTED;
		end else if (ev.msg_type == fix_session_pkg::MT_TEST_REQ) begin
			push_order(h, fix_session_pkg::ORD_HEARTBEAT);
		end else begin
			push_pulse(h, P_ACC);
			st = fix_session_pkg::ST_NORMAL;
		end
		model_st[h] = st;
	endtask

	// called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic send_event(input fix_session_pkg::event_kind_e kind, input int host,
			input fix_session_pkg::msg_type_e mt, input fix_session_pkg::validity_e val);
		fix_session_pkg::session_event_t ev;
		int   waited;
		logic taken;
		if (timed_out) begin
			return;
		end
		ev.kind     = kind;
		ev.host     = 8'(host);
		ev.msg_type = mt;
		ev.validity = val;
		waited      = 0;
		taken       = 1'b0;
		ev_drv      = ev;
		event_valid = 1'b1;
		while (!taken && waited < 200) begin
			@(posedge clk);
			if (event_ready) begin
				taken = 1'b1;
			end else begin
				waited++;
			end
		end
		#1;
		event_valid = 1'b0;
		hold_cycles = waited;
		if (!taken) begin
			report_timeout("event_ready_o");
		end else begin
			apply_model(ev);
			events_sent++;
		end
	endtask

	task automatic send_msg(input int host, input fix_session_pkg::msg_type_e mt,
			input fix_session_pkg::validity_e val);
		send_event(fix_session_pkg::EV_RX_MSG, host, mt, val);
	endtask

	task automatic send_ctl(input fix_session_pkg::event_kind_e kind, input int host);
		send_event(kind, host, fix_session_pkg::MT_LOGON, fix_session_pkg::VAL_VALID);
	endtask

	function automatic logic drained();
		logic d;
		d = event_ready && !wb_cyc;
		for (int h = 0; h < NUM_HOST; h++) begin
			d = d && pulse_head[h] == pulse_tail[h] && ord_head[h] == ord_tail[h];
		end
		return d;
	endfunction

	task automatic wait_idle();
		int   n;
		logic idle;
		if (timed_out) begin
			return;
		end
		n    = 0;
		idle = 1'b0;
		while (!idle && n < 400) begin
			@(posedge clk);
			idle = drained();
			n++;
		end
		#1;
		if (!idle) begin
			report_timeout("outstanding orders and pulses");
		end
	endtask

	initial begin
		int logons [NUM_HOST];
		void'($urandom(32'h7a28_9f32));
		arst_n      = 1'b0;
		event_valid = 1'b0;
		ev_drv      = '0;
		for (int h = 0; h < NUM_HOST; h++) begin
			model_st[h] = fix_session_pkg::ST_DISCONNECTED;
		end
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;
		@(posedge clk);
		assert (event_ready) else report_value("ready after reset", 32'd1, 32'(event_ready));
		assert (!wb_cyc && act_pv == '0) else report_text("bus or pulses active after reset");
		#1;

		test_name = "logon";
		rx_start  = rx_q.size();
		send_ctl(fix_session_pkg::EV_CONNECT, 2);
		wait_idle();
		assert (rx_q.size() - rx_start == 1)
			else report_value("logon write count", 32'd1, 32'(rx_q.size() - rx_start));
		assert (rx_q[rx_q.size()-1] == {2'd2, 4'(fix_session_pkg::ORD_LOGON)})
			else report_value("logon write", 32'({2'd2, 4'(fix_session_pkg::ORD_LOGON)}),
				32'(rx_q[rx_q.size()-1]));
		send_msg(2, fix_session_pkg::MT_LOGON, fix_session_pkg::VAL_VALID);
		send_msg(2, fix_session_pkg::MT_APP, fix_session_pkg::VAL_VALID);
		wait_idle();

		test_name = "gap_recovery";
		send_msg(2, fix_session_pkg::MT_APP, fix_session_pkg::VAL_SEQ_HIGH);
		send_msg(2, fix_session_pkg::MT_GAP_FILL, fix_session_pkg::VAL_VALID);
		send_msg(2, fix_session_pkg::MT_APP, fix_session_pkg::VAL_VALID);
		wait_idle();

		test_name = "heartbeat";
		send_ctl(fix_session_pkg::EV_TIMEOUT, 2);
		wait_idle();
		send_ctl(fix_session_pkg::EV_TIMEOUT, 2); // still no answer
		send_msg(2, fix_session_pkg::MT_APP, fix_session_pkg::VAL_VALID);
		send_msg(2, fix_session_pkg::MT_HEARTBEAT, fix_session_pkg::VAL_VALID);
		wait_idle();

		test_name = "faults";
		send_ctl(fix_session_pkg::EV_CONNECT, 1);
		send_msg(1, fix_session_pkg::MT_LOGON, fix_session_pkg::VAL_VALID);
		send_msg(1, fix_session_pkg::MT_APP, fix_session_pkg::VAL_SEQ_LOW);
		send_ctl(fix_session_pkg::EV_CONNECT, 1);
		send_msg(1, fix_session_pkg::MT_LOGON, fix_session_pkg::VAL_VALID);
		send_msg(1, fix_session_pkg::MT_APP, fix_session_pkg::VAL_INVALID);
		send_ctl(fix_session_pkg::EV_CONNECT, 1);
		send_msg(1, fix_session_pkg::MT_LOGON, fix_session_pkg::VAL_VALID);
		send_msg(1, fix_session_pkg::MT_APP, fix_session_pkg::VAL_GARBLED);
		send_ctl(fix_session_pkg::EV_END_SESSION, 1);
		send_msg(1, fix_session_pkg::MT_LOGOUT, fix_session_pkg::VAL_VALID);
		wait_idle();

		test_name = "contention";
		slow_ack  = 1'b1;
		rx_start  = rx_q.size();
		for (int h = 0; h < NUM_HOST; h++) begin
			send_ctl(fix_session_pkg::EV_CONNECT, h);
		end
		send_msg(0, fix_session_pkg::MT_LOGON, fix_session_pkg::VAL_VALID);
		send_msg(1, fix_session_pkg::MT_LOGON, fix_session_pkg::VAL_VALID); // queued behind host 0
		assert (hold_cycles > 0) else report_text("event for a busy host was not held back");
		wait_idle();
		slow_ack = 1'b0;
		logons   = '{default: 0};
		for (int i = rx_start; i < rx_q.size(); i++) begin
			if (rx_q[i][3:0] == 4'(fix_session_pkg::ORD_LOGON)) begin
				logons[int'(rx_q[i][5:4])]++;
			end
		end
		for (int h = 0; h < NUM_HOST; h++) begin
			assert (logons[h] == 1) else report_value("logon writes per host", 32'd1, 32'(logons[h]));
		end
		assert (pulse_cycle[0] > ack_cycle[0] && pulse_cycle[1] > ack_cycle[1])
			else report_text("held logon applied before its host's write was acknowledged");

		test_name = "end";
		repeat (5) @(posedge clk);
		finish_run();
	end

endmodule

`default_nettype wire
